// ==== hdl/cp0_pkg.sv ====
package cp0_pkg;

	localparam int TLBNUM = 16;
	localparam int TLB_IDX_W = 4;

	// cp0 register numbers, select 0
	localparam logic [4:0] REG_INDEX    = 5'd0;
	localparam logic [4:0] REG_ENTRYLO0 = 5'd2;
	localparam logic [4:0] REG_ENTRYLO1 = 5'd3;
	localparam logic [4:0] REG_BADVADDR = 5'd8;
	localparam logic [4:0] REG_COUNT    = 5'd9;
	localparam logic [4:0] REG_ENTRYHI  = 5'd10;
	localparam logic [4:0] REG_COMPARE  = 5'd11;
	localparam logic [4:0] REG_STATUS   = 5'd12;
	localparam logic [4:0] REG_CAUSE    = 5'd13;
	localparam logic [4:0] REG_EPC      = 5'd14;

	// register slots inside each block
	localparam logic [1:0] IDX_BADVADDR = 2'd0;
	localparam logic [1:0] IDX_STATUS   = 2'd1;
	localparam logic [1:0] IDX_CAUSE    = 2'd2;
	localparam logic [1:0] IDX_EPC      = 2'd3;
	localparam logic [1:0] IDX_COUNT    = 2'd0;
	localparam logic [1:0] IDX_COMPARE  = 2'd1;
	localparam logic [1:0] IDX_INDEX    = 2'd0;
	localparam logic [1:0] IDX_ENTRYLO0 = 2'd1;
	localparam logic [1:0] IDX_ENTRYLO1 = 2'd2;
	localparam logic [1:0] IDX_ENTRYHI  = 2'd3;

	localparam int EXC_W = 15;

	// bit positions in the exception type vector
	localparam int EXB_INT            = 14;
	localparam int EXB_ADEL_IF        = 13;
	localparam int EXB_ADEL_LD        = 12;
	localparam int EXB_ADES           = 11;
	localparam int EXB_SYS            = 10;
	localparam int EXB_BP             = 9;
	localparam int EXB_RI             = 8;
	localparam int EXB_OV             = 7;
	localparam int EXB_TLBL_REFILL_IF = 6;
	localparam int EXB_TLBL_INVAL_IF  = 5;
	localparam int EXB_TLBL_REFILL_LD = 4;
	localparam int EXB_TLBL_INVAL_LD  = 3;
	localparam int EXB_TLBS_REFILL    = 2;
	localparam int EXB_TLBS_INVAL     = 1;
	localparam int EXB_MOD            = 0;

	localparam logic [4:0] EXC_INT  = 5'h00;
	localparam logic [4:0] EXC_MOD  = 5'h01;
	localparam logic [4:0] EXC_TLBL = 5'h02;
	localparam logic [4:0] EXC_TLBS = 5'h03;
	localparam logic [4:0] EXC_ADEL = 5'h04;
	localparam logic [4:0] EXC_ADES = 5'h05;
	localparam logic [4:0] EXC_SYS  = 5'h08;
	localparam logic [4:0] EXC_BP   = 5'h09;
	localparam logic [4:0] EXC_RI   = 5'h0a;
	localparam logic [4:0] EXC_OV   = 5'h0c;

	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        g;
		logic [19:0] pfn0;
		logic [2:0]  c0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic [2:0]  c1;
		logic        d1;
		logic        v1;
	} tlb_entry_t;

	typedef enum logic [1:0] {
		TLBOP_NONE,
		TLBOP_TLBP,
		TLBOP_TLBR,
		TLBOP_TLBWI
	} tlb_op_e;

endpackage

// ==== hdl/cp0_intf.sv ====
`timescale 1ns/1ns

interface csr_if;
	logic        sel;
	logic [1:0]  idx;
	logic        wen;
	logic [31:0] wdata;
	logic [31:0] rdata;

	modport ctrl (
		output sel,
		output idx,
		output wen,
		output wdata,
		input  rdata
	);

	modport blk (
		input  sel,
		input  idx,
		input  wen,
		input  wdata,
		output rdata
	);
endinterface

interface tlb_port_if;
	import cp0_pkg::*;

	logic                 probe;
	logic                 read;
	logic                 write;
	logic                 tlb_exc;
	logic [31:0]          bad_vaddr;
	logic [18:0]          entryhi_vpn2;
	logic [7:0]           entryhi_asid;
	logic [TLB_IDX_W-1:0] index;
	tlb_entry_t           wentry;
	logic                 probe_hit;
	logic [TLB_IDX_W-1:0] probe_idx;
	tlb_entry_t           rentry;

	modport ctrl (
		output probe,
		output read,
		output write,
		output tlb_exc,
		output bad_vaddr
	);

	modport regs (
		input  probe,
		input  read,
		input  tlb_exc,
		input  bad_vaddr,
		input  probe_hit,
		input  probe_idx,
		input  rentry,
		output entryhi_vpn2,
		output entryhi_asid,
		output index,
		output wentry
	);

	modport array (
		input  probe,
		input  write,
		input  entryhi_vpn2,
		input  entryhi_asid,
		input  index,
		input  wentry,
		output probe_hit,
		output probe_idx,
		output rentry
	);
endinterface

// ==== hdl/exc_ctrl.sv ====
`timescale 1ns/1ns

module exc_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [7:0]                cp0_addr,
	input  logic                      cp0_wen,
	input  logic [31:0]               cp0_wdata,
	output logic [31:0]               cp0_rdata,
	input  logic [cp0_pkg::EXC_W-1:0] exc_type,
	input  cp0_pkg::tlb_op_e          tlb_op,
	input  logic [31:0]               bad_vaddr,
	input  logic                      exl,
	csr_if.ctrl                       st_bus,
	csr_if.ctrl                       tm_bus,
	csr_if.ctrl                       tlb_bus,
	tlb_port_if.ctrl                  tlb,
	output logic                      exc_valid,
	output logic [4:0]                exccode,
	output logic                      badvaddr_wen
);
	import cp0_pkg::*;

	// one-hot block in [4:2], slot in [1:0]
	logic [4:0] dec;
	logic       tlb_if_exc;
	logic       tlb_ld_exc;
	logic       tlb_st_exc;
	logic       tlb_any;
	logic       tlb_go;

	always_comb begin
		dec = 5'b0;
		if (cp0_addr[2:0] == 3'd0) begin
			case (cp0_addr[7:3])
				REG_BADVADDR: dec = {3'b001, IDX_BADVADDR};
				REG_STATUS:   dec = {3'b001, IDX_STATUS};
				REG_CAUSE:    dec = {3'b001, IDX_CAUSE};
				REG_EPC:      dec = {3'b001, IDX_EPC};
				REG_COUNT:    dec = {3'b010, IDX_COUNT};
				REG_COMPARE:  dec = {3'b010, IDX_COMPARE};
				REG_INDEX:    dec = {3'b100, IDX_INDEX};
				REG_ENTRYLO0: dec = {3'b100, IDX_ENTRYLO0};
				REG_ENTRYLO1: dec = {3'b100, IDX_ENTRYLO1};
				REG_ENTRYHI:  dec = {3'b100, IDX_ENTRYHI};
				default:      dec = 5'b0;
			endcase
		end
	end

	assign st_bus.sel  = dec[2];
	assign tm_bus.sel  = dec[3];
	assign tlb_bus.sel = dec[4];

	assign st_bus.idx  = dec[1:0];
	assign tm_bus.idx  = dec[1:0];
	assign tlb_bus.idx = dec[1:0];

	// a committing exception blocks software writes
	assign st_bus.wen  = dec[2] && cp0_wen && !exc_valid;
	assign tm_bus.wen  = dec[3] && cp0_wen && !exc_valid;
	assign tlb_bus.wen = dec[4] && cp0_wen && !exc_valid;

	assign st_bus.wdata  = cp0_wdata;
	assign tm_bus.wdata  = cp0_wdata;
	assign tlb_bus.wdata = cp0_wdata;

	// unmapped numbers read as zero
	assign cp0_rdata = {32{st_bus.sel}} & st_bus.rdata
		| {32{tm_bus.sel}} & tm_bus.rdata
		| {32{tlb_bus.sel}} & tlb_bus.rdata;

	assign tlb_if_exc = exc_type[EXB_TLBL_REFILL_IF] || exc_type[EXB_TLBL_INVAL_IF];
	assign tlb_ld_exc = exc_type[EXB_TLBL_REFILL_LD] || exc_type[EXB_TLBL_INVAL_LD];
	assign tlb_st_exc = exc_type[EXB_TLBS_REFILL] || exc_type[EXB_TLBS_INVAL];
	assign tlb_any    = tlb_if_exc || tlb_ld_exc || tlb_st_exc || exc_type[EXB_MOD];

	assign exc_valid = |exc_type;
	assign badvaddr_wen = exc_type[EXB_ADEL_IF] || exc_type[EXB_ADEL_LD]
		|| exc_type[EXB_ADES] || tlb_any;

	// fetch faults first, then decode/execute, then memory stage
	always_comb begin
		if (exc_type[EXB_INT])
			exccode = EXC_INT;
		else if (exc_type[EXB_ADEL_IF])
			exccode = EXC_ADEL;
		else if (tlb_if_exc)
			exccode = EXC_TLBL;
		else if (exc_type[EXB_RI])
			exccode = EXC_RI;
		else if (exc_type[EXB_SYS])
			exccode = EXC_SYS;
		else if (exc_type[EXB_BP])
			exccode = EXC_BP;
		else if (exc_type[EXB_OV])
			exccode = EXC_OV;
		else if (exc_type[EXB_ADEL_LD])
			exccode = EXC_ADEL;
		else if (exc_type[EXB_ADES])
			exccode = EXC_ADES;
		else if (tlb_ld_exc)
			exccode = EXC_TLBL;
		else if (tlb_st_exc)
			exccode = EXC_TLBS;
		else
			exccode = EXC_MOD;
	end

	assign tlb_go = !exc_valid && !exl;

	assign tlb.probe     = tlb_go && (tlb_op == TLBOP_TLBP);
	assign tlb.read      = tlb_go && (tlb_op == TLBOP_TLBR);
	assign tlb.write     = tlb_go && (tlb_op == TLBOP_TLBWI);
	assign tlb.tlb_exc   = tlb_any;
	assign tlb.bad_vaddr = bad_vaddr;

	a_no_tlb_on_exc: assert property (@(posedge clk) disable iff (rst)
		exc_valid |-> !(tlb.probe || tlb.read || tlb.write));

endmodule

// ==== hdl/cp0_status_regs.sv ====
`timescale 1ns/1ns

module cp0_status_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] pc,
	input  logic        is_slot,
	input  logic [31:0] bad_vaddr,
	input  logic        eret,
	input  logic [5:0]  int_num,
	input  logic        exc_valid,
	input  logic [4:0]  exccode,
	input  logic        badvaddr_wen,
	input  logic        timer_int,
	csr_if.blk          bus,
	output logic [31:0] epc,
	output logic        exl,
	output logic        int_happen
);
	import cp0_pkg::*;

	logic [7:0]  im;
	logic        ie;
	logic        bd;
	logic [5:0]  ip_hw;
	logic [1:0]  ip_sw;
	logic [4:0]  cause_exccode;
	logic [31:0] badvaddr;
	logic [7:0]  ip;
	logic [31:0] status;
	logic [31:0] cause;
	logic        status_wr;
	logic        cause_wr;
	logic        epc_wr;
	logic        first_exc;

	assign status_wr = bus.wen && bus.idx == IDX_STATUS;
	assign cause_wr  = bus.wen && bus.idx == IDX_CAUSE;
	assign epc_wr    = bus.wen && bus.idx == IDX_EPC;

	// nested exceptions keep the first EPC and BD
	assign first_exc = exc_valid && !exl;

	always_ff @(posedge clk) begin
		if (rst) begin
			exl <= 1'b0;
			ie  <= 1'b0;
			im  <= 8'h0;
		end else begin
			if (exc_valid)
				exl <= 1'b1;
			else if (eret)
				exl <= 1'b0;
			else if (status_wr)
				exl <= bus.wdata[1];
			if (status_wr) begin
				ie <= bus.wdata[0];
				im <= bus.wdata[15:8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bd            <= 1'b0;
			cause_exccode <= 5'h0;
			ip_hw         <= 6'h0;
			ip_sw         <= 2'h0;
		end else begin
			if (first_exc)
				bd <= is_slot;
			if (exc_valid)
				cause_exccode <= exccode;
			// timer shares ip7 with hw line 5
			ip_hw <= {int_num[5] | timer_int, int_num[4:0]};
			if (cause_wr)
				ip_sw <= bus.wdata[9:8];
		end
	end

	always_ff @(posedge clk) begin
		if (first_exc)
			epc <= is_slot ? pc - 32'd4 : pc;
		else if (epc_wr)
			epc <= bus.wdata;
		if (badvaddr_wen)
			badvaddr <= bad_vaddr;
	end

	assign ip     = {ip_hw, ip_sw};
	assign status = {9'h0, 1'b1, 6'h0, im, 6'h0, exl, ie};
	assign cause  = {bd, timer_int, 14'h0, ip, 1'b0, cause_exccode, 2'b0};

	always_comb begin
		case (bus.idx)
			IDX_BADVADDR: bus.rdata = badvaddr;
			IDX_STATUS:   bus.rdata = status;
			IDX_CAUSE:    bus.rdata = cause;
			default:      bus.rdata = epc;
		endcase
	end

	assign int_happen = !exl && ie && (|(im & ip));

	a_exc_sets_exl: assert property (@(posedge clk) disable iff (rst)
		exc_valid |=> exl);

endmodule

// ==== hdl/cp0_timer.sv ====
`timescale 1ns/1ns

module cp0_timer (
	input  logic clk,
	input  logic rst,
	csr_if.blk   bus,
	output logic timer_int
);
	import cp0_pkg::*;

	// bit 0 is the half-rate prescaler
	logic [32:0] count;
	logic [31:0] compare;
	logic        ti;
	logic        compare_wr;

	assign compare_wr = bus.wen && bus.idx == IDX_COMPARE;

	always_ff @(posedge clk) begin
		if (rst)
			count <= 33'h0;
		else if (bus.wen && bus.idx == IDX_COUNT)
			count <= {bus.wdata, 1'b0};
		else
			count <= count + 33'd1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			compare <= 32'hffff_ffff;
		else if (compare_wr)
			compare <= bus.wdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ti <= 1'b0;
		else if (compare_wr)
			ti <= 1'b0;
		else if (count[32:1] == compare)
			ti <= 1'b1;
	end

	assign timer_int = ti;
	assign bus.rdata = (bus.idx == IDX_COMPARE) ? compare : count[32:1];

endmodule

// ==== hdl/cp0_tlb_regs.sv ====
`timescale 1ns/1ns

module cp0_tlb_regs (
	input  logic clk,
	input  logic rst,
	csr_if.blk   bus,
	tlb_port_if.regs tlb
);
	import cp0_pkg::*;

	logic                 index_p;
	logic [TLB_IDX_W-1:0] index_v;
	logic [18:0]          vpn2;
	logic [7:0]           asid;
	// {pfn, c, d, v, g}
	logic [25:0]          lo0;
	logic [25:0]          lo1;

	always_ff @(posedge clk) begin
		if (rst) begin
			index_p <= 1'b0;
			index_v <= '0;
		end else if (tlb.probe) begin
			index_p <= !tlb.probe_hit;
			index_v <= tlb.probe_hit ? tlb.probe_idx : '0;
		end else if (bus.wen && bus.idx == IDX_INDEX) begin
			index_v <= bus.wdata[TLB_IDX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (tlb.tlb_exc) begin
			vpn2 <= tlb.bad_vaddr[31:13];
		end else if (tlb.read) begin
			vpn2 <= tlb.rentry.vpn2;
			asid <= tlb.rentry.asid;
		end else if (bus.wen && bus.idx == IDX_ENTRYHI) begin
			vpn2 <= bus.wdata[31:13];
			asid <= bus.wdata[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (tlb.read) begin
			lo0 <= {tlb.rentry.pfn0, tlb.rentry.c0, tlb.rentry.d0, tlb.rentry.v0,
				tlb.rentry.g};
			lo1 <= {tlb.rentry.pfn1, tlb.rentry.c1, tlb.rentry.d1, tlb.rentry.v1,
				tlb.rentry.g};
		end else begin
			if (bus.wen && bus.idx == IDX_ENTRYLO0)
				lo0 <= bus.wdata[25:0];
			if (bus.wen && bus.idx == IDX_ENTRYLO1)
				lo1 <= bus.wdata[25:0];
		end
	end

	assign tlb.entryhi_vpn2 = vpn2;
	assign tlb.entryhi_asid = asid;
	assign tlb.index        = index_v;

	// global only when both halves say so
	assign tlb.wentry = '{
		vpn2: vpn2, asid: asid, g: lo0[0] & lo1[0],
		pfn0: lo0[25:6], c0: lo0[5:3], d0: lo0[2], v0: lo0[1],
		pfn1: lo1[25:6], c1: lo1[5:3], d1: lo1[2], v1: lo1[1]
	};

	always_comb begin
		case (bus.idx)
			IDX_INDEX:    bus.rdata = {index_p, {(31 - TLB_IDX_W){1'b0}}, index_v};
			IDX_ENTRYLO0: bus.rdata = {6'h0, lo0};
			IDX_ENTRYLO1: bus.rdata = {6'h0, lo1};
			default:      bus.rdata = {vpn2, 5'h0, asid};
		endcase
	end

endmodule

// ==== hdl/tlb_array.sv ====
`timescale 1ns/1ns

module tlb_array (
	input  logic      clk,
	input  logic      rst,
	tlb_port_if.array tlb
);
	import cp0_pkg::*;

	tlb_entry_t           mem [TLBNUM];
	logic [TLBNUM-1:0]    valid;
	logic [TLBNUM-1:0]    match;
	logic [TLB_IDX_W-1:0] hit_idx;

	always_ff @(posedge clk) begin
		if (tlb.write)
			mem[tlb.index] <= tlb.wentry;
	end

	// entries never written stay out of the probe
	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else if (tlb.write)
			valid[tlb.index] <= 1'b1;
	end

	always_comb begin
		for (int i = 0; i < TLBNUM; i++) begin
			match[i] = valid[i]
				&& mem[i].vpn2 == tlb.entryhi_vpn2
				&& (mem[i].g || mem[i].asid == tlb.entryhi_asid);
		end
	end

	// entries are unique, so an OR of indexes encodes the hit
	always_comb begin
		hit_idx = '0;
		for (int i = 0; i < TLBNUM; i++) begin
			if (match[i])
				hit_idx = hit_idx | TLB_IDX_W'(i);
		end
	end

	assign tlb.probe_hit = |match;
	assign tlb.probe_idx = hit_idx;
	assign tlb.rentry    = mem[tlb.index];

	a_probe_unique: assert property (@(posedge clk) disable iff (rst)
		tlb.probe |-> $onehot0(match));

endmodule

// ==== hdl/cp0_top.sv ====
`timescale 1ns/1ns

module cp0_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [7:0]                cp0_addr,
	input  logic                      cp0_wen,
	input  logic [31:0]               cp0_wdata,
	output logic [31:0]               cp0_rdata,
	input  logic [cp0_pkg::EXC_W-1:0] exc_type,
	input  logic [31:0]               pc,
	input  logic                      is_slot,
	input  logic [31:0]               bad_vaddr,
	input  logic                      eret,
	input  logic [5:0]                int_num,
	input  cp0_pkg::tlb_op_e          tlb_op,
	output logic [31:0]               epc,
	output logic                      int_happen
);

	logic       exc_valid;
	logic [4:0] exccode;
	logic       badvaddr_wen;
	logic       timer_int;
	logic       exl;

	csr_if      st_bus ();
	csr_if      tm_bus ();
	csr_if      tlb_bus ();
	tlb_port_if tlb_port ();

	exc_ctrl u_exc_ctrl (
		.clk          (clk),
		.rst          (rst),
		.cp0_addr     (cp0_addr),
		.cp0_wen      (cp0_wen),
		.cp0_wdata    (cp0_wdata),
		.cp0_rdata    (cp0_rdata),
		.exc_type     (exc_type),
		.tlb_op       (tlb_op),
		.bad_vaddr    (bad_vaddr),
		.exl          (exl),
		.st_bus       (st_bus.ctrl),
		.tm_bus       (tm_bus.ctrl),
		.tlb_bus      (tlb_bus.ctrl),
		.tlb          (tlb_port.ctrl),
		.exc_valid    (exc_valid),
		.exccode      (exccode),
		.badvaddr_wen (badvaddr_wen)
	);

	cp0_status_regs u_status (
		.clk          (clk),
		.rst          (rst),
		.pc           (pc),
		.is_slot      (is_slot),
		.bad_vaddr    (bad_vaddr),
		.eret         (eret),
		.int_num      (int_num),
		.exc_valid    (exc_valid),
		.exccode      (exccode),
		.badvaddr_wen (badvaddr_wen),
		.timer_int    (timer_int),
		.bus          (st_bus.blk),
		.epc          (epc),
		.exl          (exl),
		.int_happen   (int_happen)
	);

	cp0_timer u_timer (
		.clk       (clk),
		.rst       (rst),
		.bus       (tm_bus.blk),
		.timer_int (timer_int)
	);

	cp0_tlb_regs u_tlb_regs (
		.clk (clk),
		.rst (rst),
		.bus (tlb_bus.blk),
		.tlb (tlb_port.regs)
	);

	tlb_array u_tlb_array (
		.clk (clk),
		.rst (rst),
		.tlb (tlb_port.array)
	);

endmodule

// ==== verif/cp0_tb.sv ====
`timescale 1ns/1ns

module cp0_tb;
	import cp0_pkg::*;

	localparam int REG_ROWS = 9;
	localparam int EXC_ROWS = 15;
	localparam int INT_ROWS = 5;
	localparam int TMR_ROWS = 6;
	localparam int TLB_ROWS = 6;
	localparam int TABLE_ROWS = REG_ROWS + EXC_ROWS + INT_ROWS + TMR_ROWS + TLB_ROWS;
	localparam int TIMEOUT_CYCLES = TABLE_ROWS * 8 + 100;

	logic              clk;
	logic              rst;
	logic [7:0]        cp0_addr;
	logic              cp0_wen;
	logic [31:0]       cp0_wdata;
	logic [31:0]       cp0_rdata;
	logic [EXC_W-1:0]  exc_type;
	logic [31:0]       pc;
	logic              is_slot;
	logic [31:0]       bad_vaddr;
	logic              eret;
	logic [5:0]        int_num;
	tlb_op_e           tlb_op;
	logic [31:0]       epc;
	logic              int_happen;

	logic [31:0] lfsr = 32'hc6a5;
	int          errors = 0;
	int          cycle_count = 0;

	// reference state
	logic [31:0] eh_model;
	logic [31:0] bv_model = 32'hx;
	logic [31:0] m_hi  [TLB_ROWS];
	logic [31:0] m_lo0 [TLB_ROWS];
	logic [31:0] m_lo1 [TLB_ROWS];

	logic [4:0] wr_reg_tab [REG_ROWS] = '{REG_STATUS, REG_CAUSE, REG_EPC, REG_COMPARE,
		REG_COUNT, REG_INDEX, REG_ENTRYHI, REG_ENTRYLO0, REG_ENTRYLO1};

	int exc_bit_tab [EXC_ROWS] = '{EXB_INT, EXB_ADEL_IF, EXB_ADEL_LD, EXB_ADES, EXB_SYS,
		EXB_BP, EXB_RI, EXB_OV, EXB_TLBL_REFILL_IF, EXB_TLBL_INVAL_IF, EXB_TLBL_REFILL_LD,
		EXB_TLBL_INVAL_LD, EXB_TLBS_REFILL, EXB_TLBS_INVAL, EXB_MOD};
	logic [4:0] exc_code_tab [EXC_ROWS] = '{EXC_INT, EXC_ADEL, EXC_ADEL, EXC_ADES, EXC_SYS,
		EXC_BP, EXC_RI, EXC_OV, EXC_TLBL, EXC_TLBL, EXC_TLBL, EXC_TLBL, EXC_TLBS, EXC_TLBS,
		EXC_MOD};
	logic exc_slot_tab [EXC_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1,
		1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

	logic [7:0] int_im_tab  [INT_ROWS] = '{8'hfc, 8'h00, 8'h01, 8'h02, 8'h80};
	logic [5:0] int_num_tab [INT_ROWS] = '{6'h01, 6'h3f, 6'h00, 6'h00, 6'h20};
	logic [1:0] int_sw_tab  [INT_ROWS] = '{2'h0, 2'h3, 2'h1, 2'h1, 2'h0};

	int tmr_k_tab [TMR_ROWS] = '{0, 1, 2, 3, 4, 7};

	logic [3:0] tlb_idx_tab [TLB_ROWS] = '{4'd3, 4'd0, 4'd9, 4'd15, 4'd6, 4'd12};
	logic       tlb_g_tab   [TLB_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

	cp0_top dut (
		.clk        (clk),
		.rst        (rst),
		.cp0_addr   (cp0_addr),
		.cp0_wen    (cp0_wen),
		.cp0_wdata  (cp0_wdata),
		.cp0_rdata  (cp0_rdata),
		.exc_type   (exc_type),
		.pc         (pc),
		.is_slot    (is_slot),
		.bad_vaddr  (bad_vaddr),
		.eret       (eret),
		.int_num    (int_num),
		.tlb_op     (tlb_op),
		.epc        (epc),
		.int_happen (int_happen)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	end

	// galois form, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | 32'(lfsr[0]);
		end
	endtask

	// value a register reads back after software writes d
	function automatic logic [31:0] readback_value(input logic [4:0] r, input logic [31:0] d);
		case (r)
			REG_STATUS:   readback_value = (d & 32'h0000_ff03) | 32'h0040_0000;
			REG_CAUSE:    readback_value = d & 32'h0000_0300;
			REG_EPC:      readback_value = d;
			REG_COMPARE:  readback_value = d;
			REG_COUNT:    readback_value = d;
			REG_INDEX:    readback_value = d & 32'h0000_000f;
			REG_ENTRYHI:  readback_value = d & 32'hffff_e0ff;
			REG_ENTRYLO0: readback_value = d & 32'h03ff_ffff;
			REG_ENTRYLO1: readback_value = d & 32'h03ff_ffff;
			default:      readback_value = 32'h0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic write_reg(input logic [4:0] r, input logic [31:0] d);
		cp0_addr  = {r, 3'b000};
		cp0_wdata = d;
		cp0_wen   = 1'b1;
		next_cycle();
		cp0_wen = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] r, output logic [31:0] v);
		cp0_addr = {r, 3'b000};
		#1;
		v = cp0_rdata;
	endtask

	task automatic issue_tlb_op(input tlb_op_e op);
		tlb_op = op;
		next_cycle();
		tlb_op = TLBOP_NONE;
	endtask

	task automatic probe_key(input logic [31:0] hi, output logic [31:0] idx);
		write_reg(REG_ENTRYHI, hi);
		issue_tlb_op(TLBOP_TLBP);
		read_reg(REG_INDEX, idx);
	endtask

	task automatic reset_checks();
		logic [31:0] v;
		read_reg(REG_STATUS, v);
		check_value("status after reset", v, 32'h0040_0000);
		read_reg(REG_COMPARE, v);
		check_value("compare after reset", v, 32'hffff_ffff);
		read_reg(REG_INDEX, v);
		check_value("index after reset", v, 32'h0);
		read_reg(REG_COUNT, v);
		check_value("count after reset", v, 32'h0);
		check_value("int_happen after reset", 32'(int_happen), 32'h0);
	endtask

	task automatic register_tests();
		logic [31:0] d;
		logic [31:0] v;
		for (int i = 0; i < REG_ROWS; i++) begin
			take_bits(32, d);
			write_reg(wr_reg_tab[i], d);
			read_reg(wr_reg_tab[i], v);
			check_value($sformatf("cp0_rdata (reg %0d)", wr_reg_tab[i]), v,
				readback_value(wr_reg_tab[i], d));
			if (wr_reg_tab[i] == REG_ENTRYHI)
				eh_model = readback_value(REG_ENTRYHI, d);
		end
		write_reg(REG_STATUS, 32'h0);
	endtask

	task automatic exception_tests();
		logic [31:0] pc_v;
		logic [31:0] bv;
		logic [31:0] v;
		logic [31:0] epc_first;
		logic        slot;
		int          b;
		for (int i = 0; i < EXC_ROWS; i++) begin
			b    = exc_bit_tab[i];
			slot = exc_slot_tab[i];
			take_bits(30, pc_v);
			pc_v = pc_v << 2;
			take_bits(32, bv);
			exc_type  = 15'(1) << b;
			pc        = pc_v;
			is_slot   = slot;
			bad_vaddr = bv;
			next_cycle();
			exc_type = '0;
			// address and tlb classes latch badvaddr, tlb class also refills vpn2
			if (b <= EXB_TLBL_REFILL_IF || (b >= EXB_ADES && b <= EXB_ADEL_IF))
				bv_model = bv;
			if (b <= EXB_TLBL_REFILL_IF)
				eh_model[31:13] = bv[31:13];
			epc_first = slot ? pc_v - 32'd4 : pc_v;
			read_reg(REG_CAUSE, v);
			check_value("cause.exccode", 32'(v[6:2]), 32'(exc_code_tab[i]));
			check_value("cause.bd", 32'(v[31]), 32'(slot));
			check_value("epc", epc, epc_first);
			read_reg(REG_STATUS, v);
			check_value("status.exl", 32'(v[1]), 32'h1);
			read_reg(REG_BADVADDR, v);
			check_value("badvaddr", v, bv_model);
			read_reg(REG_ENTRYHI, v);
			check_value("entryhi", v, eh_model);

			// nested syscall keeps epc and bd
			exc_type = 15'(1) << EXB_SYS;
			pc       = pc_v + 32'h100;
			is_slot  = !slot;
			next_cycle();
			exc_type = '0;
			read_reg(REG_CAUSE, v);
			check_value("cause.exccode (nested)", 32'(v[6:2]), 32'(EXC_SYS));
			check_value("cause.bd (nested)", 32'(v[31]), 32'(slot));
			check_value("epc (nested)", epc, epc_first);

			eret = 1'b1;
			next_cycle();
			eret = 1'b0;
			read_reg(REG_STATUS, v);
			check_value("status.exl after eret", 32'(v[1]), 32'h0);
		end
	endtask

	task automatic interrupt_tests();
		logic [31:0] v;
		logic [5:0]  prev_num;
		logic        exp;
		read_reg(REG_COUNT, v);
		write_reg(REG_COMPARE, v - 32'd1);
		next_cycle();
		prev_num = int_num;
		for (int i = 0; i < INT_ROWS; i++) begin
			write_reg(REG_STATUS, {16'h0, int_im_tab[i], 8'h01});
			write_reg(REG_CAUSE, {22'h0, int_sw_tab[i], 8'h00});
			int_num = int_num_tab[i];
			read_reg(REG_CAUSE, v);
			check_value("cause.ip[7:2] before sample", 32'(v[15:10]), 32'(prev_num));
			next_cycle();
			prev_num = int_num_tab[i];
			read_reg(REG_CAUSE, v);
			check_value("cause.ip[7:2]", 32'(v[15:10]), 32'(int_num_tab[i]));
			check_value("cause.ip[1:0]", 32'(v[9:8]), 32'(int_sw_tab[i]));
			exp = |(int_im_tab[i] & {int_num_tab[i], int_sw_tab[i]});
			check_value("int_happen", 32'(int_happen), 32'(exp));

			exc_type = 15'(1) << EXB_SYS;
			next_cycle();
			exc_type = '0;
			check_value("int_happen with exl set", 32'(int_happen), 32'h0);
			next_cycle();
			check_value("int_happen with exl set", 32'(int_happen), 32'h0);
			eret = 1'b1;
			next_cycle();
			eret = 1'b0;
			check_value("int_happen after eret", 32'(int_happen), 32'(exp));
		end
		int_num = 6'h0;
		write_reg(REG_STATUS, 32'h0);
		next_cycle();
	endtask

	task automatic timer_tests();
		logic [31:0] c;
		logic [31:0] v;
		logic [31:0] w;
		logic [31:0] cmp;
		logic [31:0] cnt_exp;
		logic        ti_exp;
		logic        ip7_exp;
		write_reg(REG_STATUS, 32'h0000_8001);
		write_reg(REG_COMPARE, 32'hffff_ffff);
		for (int i = 0; i < TMR_ROWS; i++) begin
			take_bits(31, c);
			write_reg(REG_COUNT, c);
			repeat (tmr_k_tab[i]) next_cycle();
			read_reg(REG_COUNT, v);
			check_value("count", v, c + 32'(tmr_k_tab[i] / 2));
		end

		take_bits(31, c);
		write_reg(REG_COUNT, c);
		cmp = c + 32'd3;
		write_reg(REG_COMPARE, cmp);
		ti_exp  = 1'b0;
		ip7_exp = 1'b0;
		// ip7 follows ti one cycle later
		for (int k = 0; k < 12; k++) begin
			cnt_exp = c + 32'((k + 1) / 2);
			read_reg(REG_COUNT, v);
			check_value("count (timer)", v, cnt_exp);
			read_reg(REG_CAUSE, w);
			check_value("cause.ti", 32'(w[30]), 32'(ti_exp));
			check_value("int_happen (timer)", 32'(int_happen), 32'(ip7_exp));
			ip7_exp = ti_exp;
			ti_exp  = ti_exp || (cnt_exp == cmp);
			next_cycle();
		end
		read_reg(REG_CAUSE, w);
		check_value("cause.ti after match", 32'(w[30]), 32'h1);
		check_value("int_happen after match", 32'(int_happen), 32'h1);

		read_reg(REG_COUNT, v);
		write_reg(REG_COMPARE, v + 32'd1000);
		read_reg(REG_CAUSE, w);
		check_value("cause.ti after compare write", 32'(w[30]), 32'h0);
		next_cycle();
		check_value("int_happen after compare write", 32'(int_happen), 32'h0);
		write_reg(REG_STATUS, 32'h0);
	endtask

	task automatic tlb_tests();
		logic [31:0] r;
		logic [31:0] v;
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic [25:0] lo0;
		logic [25:0] lo1;
		for (int i = 0; i < TLB_ROWS; i++) begin
			take_bits(19, r);
			vpn2 = r[18:0];
			take_bits(8, r);
			asid = r[7:0];
			take_bits(26, r);
			lo0 = r[25:0];
			take_bits(26, r);
			lo1 = r[25:0];
			// entry is global only if both halves carry G
			if (tlb_g_tab[i]) begin
				lo0[0] = 1'b1;
				lo1[0] = 1'b1;
			end else begin
				lo1[0] = 1'b0;
			end
			m_hi[i]  = {vpn2, 5'h0, asid};
			m_lo0[i] = {6'h0, lo0[25:1], tlb_g_tab[i]};
			m_lo1[i] = {6'h0, lo1[25:1], tlb_g_tab[i]};
			write_reg(REG_ENTRYHI, m_hi[i]);
			write_reg(REG_ENTRYLO0, {6'h0, lo0});
			write_reg(REG_ENTRYLO1, {6'h0, lo1});
			write_reg(REG_INDEX, 32'(tlb_idx_tab[i]));
			issue_tlb_op(TLBOP_TLBWI);
		end

		for (int i = 0; i < TLB_ROWS; i++) begin
			write_reg(REG_INDEX, 32'(tlb_idx_tab[i]));
			issue_tlb_op(TLBOP_TLBR);
			read_reg(REG_ENTRYHI, v);
			check_value("entryhi after tlbr", v, m_hi[i]);
			read_reg(REG_ENTRYLO0, v);
			check_value("entrylo0 after tlbr", v, m_lo0[i]);
			read_reg(REG_ENTRYLO1, v);
			check_value("entrylo1 after tlbr", v, m_lo1[i]);
		end

		for (int i = 0; i < TLB_ROWS; i++) begin
			r = m_hi[i] ^ (tlb_g_tab[i] ? 32'h0000_005a : 32'h0);
			probe_key(r, v);
			check_value("index after tlbp hit", v, 32'(tlb_idx_tab[i]));
		end

		// wrong asid on a private entry
		probe_key(m_hi[0] ^ 32'h0000_0001, v);
		check_value("index after tlbp miss", v, 32'h8000_0000);
		take_bits(19, r);
		probe_key({r[18:0], 13'h0}, v);
		check_value("index after tlbp miss", v, 32'h8000_0000);
	endtask

	initial begin
		rst       = 1'b1;
		cp0_addr  = 8'h0;
		cp0_wen   = 1'b0;
		cp0_wdata = 32'h0;
		exc_type  = '0;
		pc        = 32'h0;
		is_slot   = 1'b0;
		bad_vaddr = 32'h0;
		eret      = 1'b0;
		int_num   = 6'h0;
		tlb_op    = TLBOP_NONE;
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;

		reset_checks();
		register_tests();
		exception_tests();
		interrupt_tests();
		timer_tests();
		tlb_tests();

		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
hdl/cp0_pkg.sv
hdl/cp0_intf.sv
hdl/exc_ctrl.sv
hdl/cp0_status_regs.sv
hdl/cp0_timer.sv
hdl/cp0_tlb_regs.sv
hdl/tlb_array.sv
hdl/cp0_top.sv
verif/cp0_tb.sv
